//--- all.f
verilog/bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/addr_decoder.sv
verilog/sram_bank.sv
verilog/boot_rom.sv
verilog/resp_mux.sv
verilog/debug_req_gate.sv
verilog/mem_harness.sv
tb/mem_harness_sva.sv
tb/tb_mem_harness.sv

//--- run.sh
#!/bin/sh
# Builds the memory harness testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_mem_harness \
  -Mdir obj_dir -o tb_mem_harness
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mem_harness > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
  exit 0
else
  echo "Pass line not found in $LOG"
  exit 1
fi

//--- tb/mem_harness_sva.sv
// Timing assertions for the memory harness top level, attached to it with bind
`timescale 1ns/1ns

module mem_harness_sva import soc_map_pkg::*; (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic rvalid_o,
  input logic err_o,
  input logic debug_req_o
);

  int unsigned since_rst_q;

  // Saturates once the hold-off window is over
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_rst_q <= 0;
    end else if (since_rst_q < DebugDelayCycles) begin
      since_rst_q <= since_rst_q + 1;
    end
  end

  rvalid_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rvalid_o == $past(req_i)
  ) else $error("response strobe is not exactly one cycle after the request");

  err_needs_rvalid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) err_o |-> rvalid_o
  ) else $error("error flag raised without a response strobe");

  debug_held_off: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (since_rst_q < DebugDelayCycles) |-> !debug_req_o
  ) else $error("debug request passed during the hold-off window");

endmodule

bind mem_harness mem_harness_sva sva0 (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .req_i       ( req_i       ),
  .rvalid_o    ( rvalid_o    ),
  .err_o       ( err_o       ),
  .debug_req_o ( debug_req_o )
);

//--- tb/mem_vectors.txt
# name op addr be wdata exp_data exp_err b2b
# op is r or w, hex fields, exp_err 0 or 1, b2b 1 issues the next line on the next cycle
rom_rd_0 r 00010000 ff 0000000000000000 b007c0de00000000 0 0
rom_rd_5 r 00010028 ff 0000000000000000 b007c0de00000005 0 0
rom_rd_15 r 00010078 ff 0000000000000000 b007c0de0000000f 0 0
dram_wr_b0 w 80000000 ff 0123456789abcdef 0000000000000000 0 0
dram_wr_b1 w 80000008 ff fedcba9876543210 0000000000000000 0 0
dram_wr_b2 w 80000010 ff a5a5a5a55a5a5a5a 0000000000000000 0 0
dram_wr_b3 w 80000018 ff 0f1e2d3c4b5a6978 0000000000000000 0 0
dram_wr_b0_i1 w 80000020 ff 1122334455667788 0000000000000000 0 0
dram_rd_b0 r 80000000 ff 0000000000000000 0123456789abcdef 0 0
dram_rd_b1 r 80000008 ff 0000000000000000 fedcba9876543210 0 0
dram_rd_b2 r 80000010 ff 0000000000000000 a5a5a5a55a5a5a5a 0 0
dram_rd_b3 r 80000018 ff 0000000000000000 0f1e2d3c4b5a6978 0 0
dram_rd_b0_i1 r 80000020 ff 0000000000000000 1122334455667788 0 0
be_wr_low w 80000000 0f 99aabbccddeeff00 0000000000000000 0 0
be_rd_low r 80000000 ff 0000000000000000 01234567ddeeff00 0 0
be_wr_mix w 80000018 a5 cccccccccccccccc 0000000000000000 0 0
be_rd_mix r 80000018 ff 0000000000000000 cc1ecc3c4bcc69cc 0 0
err_unmapped r 40000000 ff 0000000000000000 0000000000000000 1 0
err_dram_end r 80000800 ff 0000000000000000 0000000000000000 1 0
err_rom_wr w 00010008 ff deadbeefdeadbeef 0000000000000000 1 0
rom_rd_after r 00010008 ff 0000000000000000 b007c0de00000001 0 0
b2b_rd_b1 r 80000008 ff 0000000000000000 fedcba9876543210 0 1
b2b_rd_b2 r 80000010 ff 0000000000000000 a5a5a5a55a5a5a5a 0 1
b2b_rd_rom r 00010010 ff 0000000000000000 b007c0de00000002 0 1
b2b_rd_err r 40000000 ff 0000000000000000 0000000000000000 1 1
b2b_rd_b3 r 80000018 ff 0000000000000000 cc1ecc3c4bcc69cc 0 0

//--- tb/tb_mem_harness.sv
// Self-checking testbench for the memory harness, run from the transaction vector file
`timescale 1ns/1ns

module tb_mem_harness import bus_pkg::*; import soc_map_pkg::*; ();

  localparam int unsigned RespTimeout  = 50;
  localparam int unsigned DebugTimeout = 100;

  logic  clk_i;
  logic  rst_ni;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  be_t   be_i;
  data_t wdata_i;
  logic  rvalid_o;
  data_t rdata_o;
  logic  err_o;
  logic  debug_req_i;
  logic  debug_enable_i;
  logic  debug_req_o;

  int unsigned check_errors;
  int unsigned other_errors;
  int unsigned num_vectors;
  bit          timed_out;

  mem_harness dut0 (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_i          ( req_i          ),
    .we_i           ( we_i           ),
    .addr_i         ( addr_i         ),
    .be_i           ( be_i           ),
    .wdata_i        ( wdata_i        ),
    .rvalid_o       ( rvalid_o       ),
    .rdata_o        ( rdata_o        ),
    .err_o          ( err_o          ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    assert (act == exp) else begin
      $display("CHECK FAILED %0s %0s: expected %0h, actual %0h", name, field, exp, act);
      check_errors++;
    end
  endtask

  // Steps one clock at a time until the response strobe shows up
  task automatic wait_rvalid();
    int unsigned cycles;
    cycles = 0;
    while (!rvalid_o && cycles < RespTimeout) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!rvalid_o) begin
      $display("ERROR: no response within %0d cycles", RespTimeout);
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  // Both debug inputs are high since reset, so the gate opens on its own
  task automatic check_debug_gate();
    int unsigned cycles;
    cycles = 0;
    while (!debug_req_o && cycles < DebugTimeout) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!debug_req_o) begin
      $display("ERROR: debug request never passed the gate after reset");
      other_errors++;
      timed_out = 1'b1;
      return;
    end
    check_value("dbg_delay", "cycles", 64'(DebugDelayCycles), 64'(cycles));
    debug_enable_i = 1'b0;
    @(posedge clk_i);
    #1;
    check_value("dbg_disable", "debug_req", 64'd0, 64'(debug_req_o));
    debug_enable_i = 1'b1;
    @(posedge clk_i);
    #1;
    check_value("dbg_enable", "debug_req", 64'd1, 64'(debug_req_o));
    // No request in, nothing out
    debug_req_i = 1'b0;
    @(posedge clk_i);
    #1;
    check_value("dbg_req_low", "debug_req", 64'd0, 64'(debug_req_o));
    debug_req_i = 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // Vector-driven transactions
  // --------------------------------------------------------------------------
  task automatic run_vectors();
    int               fd;
    int               n;
    int               b2b;
    logic [8*160-1:0] line_buf;
    logic [8*16-1:0]  name_raw;
    logic [7:0]       op;
    addr_t            addr;
    be_t              be;
    data_t            wdata;
    data_t            exp_data;
    data_t            exp_err;
    string            name;
    fd = $fopen("tb/mem_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open the vector file tb/mem_vectors.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd) && !timed_out) begin
      line_buf = '0;
      n = $fgets(line_buf, fd);
      n = $sscanf(line_buf, "%s %s %h %h %h %h %d %d",
                  name_raw, op, addr, be, wdata, exp_data, exp_err, b2b);
      // Comment and blank lines do not parse to all eight fields
      if (n == 8) begin
        num_vectors++;
        name    = $sformatf("%0s", name_raw);
        req_i   = 1'b1;
        we_i    = (op == "w");
        addr_i  = addr;
        be_i    = be;
        wdata_i = wdata;
        @(posedge clk_i);
        #1;
        req_i = 1'b0;
        we_i  = 1'b0;
        wait_rvalid();
        if (!timed_out) begin
          check_value(name, "err", exp_err, 64'(err_o));
          // Write data is only defined on the error path
          if (op == "r" || exp_err != 0) begin
            check_value(name, "rdata", exp_data, rdata_o);
          end
          if (b2b == 0) begin
            @(posedge clk_i);
            #1;
          end
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    rst_ni         = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    debug_req_i    = 1'b1;
    debug_enable_i = 1'b1;
    check_errors   = 0;
    other_errors   = 0;
    num_vectors    = 0;
    timed_out      = 1'b0;

    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    check_debug_gate();
    if (!timed_out) begin
      run_vectors();
    end
    if (num_vectors == 0) begin
      $display("ERROR: no transactions were read from the vector file");
      other_errors++;
    end

    $display("Errors: %0d failed checks, %0d other errors, %0d transactions",
             check_errors, other_errors, num_vectors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/addr_decoder.sv
// Combinational address decoder that routes each request to ROM, a DRAM bank or the error path
`timescale 1ns/1ns

module addr_decoder import bus_pkg::*; import soc_map_pkg::*; (
  input  logic                req_i,
  input  logic                we_i,
  input  addr_t               addr_i,
  output logic [NumBanks-1:0] bank_req_o,
  output bank_idx_t           bank_idx_o,
  output bank_sel_t           bank_sel_o,
  output logic                rom_req_o,
  output rom_idx_t            rom_idx_o,
  output target_t             target_o
);

  logic  rom_hit;
  logic  dram_hit;
  addr_t rom_off;
  addr_t dram_off;

  // Region compares on the byte address
  assign rom_hit  = (addr_i >= RomBase) && (addr_i < RomBase + RomSize);
  assign dram_hit = (addr_i >= DramBase) && (addr_i < DramBase + DramSize);

  assign rom_off  = addr_i - RomBase;
  assign dram_off = addr_i - DramBase;

  // Bank from the lowest word bits, index above them
  assign rom_idx_o  = rom_off[WordOffBits +: RomIdxBits];
  assign bank_sel_o = dram_off[WordOffBits +: BankSelBits];
  assign bank_idx_o = dram_off[WordOffBits + BankSelBits +: BankIdxBits];

  // ROM is read-only
  assign rom_req_o = req_i && rom_hit && !we_i;

  // One-hot bank strobe
  always_comb begin
    bank_req_o = '0;
    if (req_i && dram_hit) begin
      bank_req_o[bank_sel_o] = 1'b1;
    end
  end

  always_comb begin
    if (rom_hit && !we_i) begin
      target_o = TgtRom;
    end else if (dram_hit) begin
      target_o = TgtDram;
    end else begin
      // Unmapped, or a write into ROM
      target_o = TgtErr;
    end
  end

endmodule

//--- verilog/boot_rom.sv
// Boot ROM with fixed contents and a registered read, one cycle from request to data
`timescale 1ns/1ns

module boot_rom import bus_pkg::*; import soc_map_pkg::*; (
  input  logic     clk_i,
  input  logic     req_i,
  input  rom_idx_t idx_i,
  output data_t    rdata_o
);

  data_t rom_table [RomWords];

  // Contents come from the signature rule
  always_comb begin
    for (int k = 0; k < RomWords; k++) begin
      rom_table[k] = rom_word(rom_idx_t'(k));
    end
  end

  // Output holds its value between requests
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom_table[idx_i];
    end
  end

endmodule

//--- verilog/bus_pkg.sv
// Request and response bus widths and types, shared by all RTL blocks of the harness
package bus_pkg;

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 64;
  localparam int unsigned BeWidth     = DataWidth / 8;
  // Byte offset bits below the word address
  localparam int unsigned WordOffBits = $clog2(BeWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // --------------------------------------------------------------------------
  // Decoded target codes
  // --------------------------------------------------------------------------
  typedef logic [1:0] target_t;

  localparam target_t TgtRom  = 2'd0;
  localparam target_t TgtDram = 2'd1;
  localparam target_t TgtErr  = 2'd2;

endpackage

//--- verilog/debug_req_gate.sv
// Gate that holds debug requests off after reset and passes them only while enabled
`timescale 1ns/1ns

module debug_req_gate import soc_map_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  dbg_cnt_t cnt_q;
  logic     cnt_done;

  assign cnt_done = (cnt_q == '0);

  // Countdown stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= dbg_cnt_t'(DebugDelayCycles);
    end else if (!cnt_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Request passes straight through once the window has closed
  assign debug_req_o = cnt_done && debug_enable_i && debug_req_i;

endmodule

//--- verilog/mem_harness.sv
// Memory harness top level that wires decoder, banks, ROM, response mux and debug gate
`timescale 1ns/1ns

module mem_harness import bus_pkg::*; import soc_map_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  output logic  rvalid_o,
  output data_t rdata_o,
  output logic  err_o,
  input  logic  debug_req_i,
  input  logic  debug_enable_i,
  output logic  debug_req_o
);

  logic [NumBanks-1:0] bank_req;
  bank_idx_t           bank_idx;
  bank_sel_t           bank_sel;
  logic                rom_req;
  rom_idx_t            rom_idx;
  target_t             target;
  data_t [NumBanks-1:0] bank_rdata;
  data_t               rom_rdata;

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------
  addr_decoder i_addr_decoder (
    .req_i      ( req_i    ),
    .we_i       ( we_i     ),
    .addr_i     ( addr_i   ),
    .bank_req_o ( bank_req ),
    .bank_idx_o ( bank_idx ),
    .bank_sel_o ( bank_sel ),
    .rom_req_o  ( rom_req  ),
    .rom_idx_o  ( rom_idx  ),
    .target_o   ( target   )
  );

  // --------------------------------------------------------------------------
  // Memories
  // --------------------------------------------------------------------------
  for (genvar g = 0; g < NumBanks; g++) begin : gen_banks
    sram_bank i_sram_bank (
      .clk_i   ( clk_i         ),
      .req_i   ( bank_req[g]   ),
      .we_i    ( we_i          ),
      .idx_i   ( bank_idx      ),
      .be_i    ( be_i          ),
      .wdata_i ( wdata_i       ),
      .rdata_o ( bank_rdata[g] )
    );
  end

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .idx_i   ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  // --------------------------------------------------------------------------
  // Response and debug gate
  // --------------------------------------------------------------------------
  resp_mux i_resp_mux (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( req_i      ),
    .target_i     ( target     ),
    .bank_sel_i   ( bank_sel   ),
    .bank_rdata_i ( bank_rdata ),
    .rom_rdata_i  ( rom_rdata  ),
    .rvalid_o     ( rvalid_o   ),
    .err_o        ( err_o      ),
    .rdata_o      ( rdata_o    )
  );

  debug_req_gate i_debug_req_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

//--- verilog/resp_mux.sv
// Response stage that aligns the decoded target with memory read data and flags errors
`timescale 1ns/1ns

module resp_mux import bus_pkg::*; import soc_map_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  target_t              target_i,
  input  bank_sel_t            bank_sel_i,
  input  data_t [NumBanks-1:0] bank_rdata_i,
  input  data_t                rom_rdata_i,
  output logic                 rvalid_o,
  output logic                 err_o,
  output data_t                rdata_o
);

  logic      valid_q;
  target_t   target_q;
  bank_sel_t bank_sel_q;

  // Sampled on the same edge as the memories
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= 1'b0;
      target_q   <= TgtErr;
      bank_sel_q <= '0;
    end else begin
      valid_q <= req_i;
      if (req_i) begin
        target_q   <= target_i;
        bank_sel_q <= bank_sel_i;
      end
    end
  end

  assign rvalid_o = valid_q;
  assign err_o    = valid_q && (target_q == TgtErr);

  always_comb begin
    case (target_q)
      TgtDram: rdata_o = bank_rdata_i[bank_sel_q];
      TgtRom:  rdata_o = rom_rdata_i;
      default: rdata_o = '0;
    endcase
  end

endmodule

//--- verilog/soc_map_pkg.sv
// Memory map of the harness, imported by the decoder, the memories and the debug gate
package soc_map_pkg;

  // --------------------------------------------------------------------------
  // Boot ROM region
  // --------------------------------------------------------------------------
  localparam logic [31:0] RomBase      = 32'h0001_0000;
  localparam int unsigned RomWords     = 16;
  localparam int unsigned RomIdxBits   = $clog2(RomWords);
  // Eight bytes per word
  localparam logic [31:0] RomSize      = 32'(RomWords * 8);
  localparam logic [31:0] RomSignature = 32'hB007_C0DE;

  typedef logic [RomIdxBits-1:0] rom_idx_t;

  // Signature in the upper half and the word index in the lower half
  function automatic logic [63:0] rom_word(rom_idx_t idx);
    return {RomSignature, 32'(idx)};
  endfunction

  // --------------------------------------------------------------------------
  // DRAM region, word-interleaved over the banks
  // --------------------------------------------------------------------------
  localparam logic [31:0] DramBase    = 32'h8000_0000;
  localparam int unsigned NumBanks    = 4;
  localparam int unsigned BankWords   = 64;
  localparam int unsigned BankSelBits = $clog2(NumBanks);
  localparam int unsigned BankIdxBits = $clog2(BankWords);
  localparam logic [31:0] DramSize    = 32'(NumBanks * BankWords * 8);

  typedef logic [BankSelBits-1:0] bank_sel_t;
  typedef logic [BankIdxBits-1:0] bank_idx_t;

  // Hold-off window for debug requests after reset
  localparam int unsigned DebugDelayCycles = 20;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  typedef logic [DebugCntWidth-1:0] dbg_cnt_t;

endpackage

//--- verilog/sram_bank.sv
// One interleaved DRAM bank with byte-enabled writes and a one-cycle registered read
`timescale 1ns/1ns

module sram_bank import bus_pkg::*; import soc_map_pkg::*; (
  input  logic      clk_i,
  input  logic      req_i,
  input  logic      we_i,
  input  bank_idx_t idx_i,
  input  be_t       be_i,
  input  data_t     wdata_i,
  output data_t     rdata_o
);

  data_t mem_q [BankWords];

  // --------------------------------------------------------------------------
  // Storage and read port
  // --------------------------------------------------------------------------
  // Read returns the word as it was before a write in the same cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem_q[idx_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

endmodule
